//--- virtual_port_udp.f
hdl/net_header_pkg.sv
hdl/port_state_pkg.sv
hdl/udp_payload_buffer.sv
hdl/ipv4_checksum_calculator.sv
hdl/frame_check_sequence_generator.sv
hdl/ethernet_frame_generator.sv
hdl/virtual_port_udp.sv
test/virtual_port_udp_properties.sv
test/virtual_port_udp_tb.sv

//--- test/virtual_port_udp_tb.sv
`default_nettype none

module virtual_port_udp_tb;

    localparam int PACKET_COUNT = 8;
    localparam int MAX_PAYLOAD  = 1472;

    logic        clock;
    logic        rst_n;
    logic [47:0] mac_source;
    logic [47:0] mac_destination;
    logic [31:0] ipv4_source;
    logic [31:0] ipv4_destination;
    logic [15:0] udp_source;
    logic [15:0] udp_destination;
    logic [8:0]  module_transmit_data;
    logic        module_transmit_data_enable;
    logic        transmit_data_enable;
    wire         transmit_ready;
    wire  [8:0]  transmit_data;
    wire         transmit_data_valid;

    integer      seed;
    int          lengths [PACKET_COUNT];
    int          timeout_cycles;
    int          frames_received;
    logic [15:0] next_identification;
    logic [7:0]  payload_bytes [$];
    logic [7:0]  frame_bytes [$];
    logic [8:0]  expected_bytes [$];            // Bit 8 marks the final byte

    virtual_port_udp dut (
        .clock                       (clock),
        .rst_n                       (rst_n),
        .mac_source                  (mac_source),
        .mac_destination             (mac_destination),
        .ipv4_source                 (ipv4_source),
        .ipv4_destination            (ipv4_destination),
        .udp_source                  (udp_source),
        .udp_destination             (udp_destination),
        .module_transmit_data        (module_transmit_data),
        .module_transmit_data_enable (module_transmit_data_enable),
        .transmit_data_enable        (transmit_data_enable),
        .transmit_ready              (transmit_ready),
        .transmit_data               (transmit_data),
        .transmit_data_valid         (transmit_data_valid)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference frame model

    task automatic append_field(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            frame_bytes.push_back(value[8*i +: 8]);     // Network order
        end
    endtask

    function automatic logic [15:0] header_checksum_of(input int first);
        logic [31:0] sum;
        sum = 32'd0;
        for (int i = first; i < first + 20; i += 2) begin
            sum = sum + {16'h0000, frame_bytes[i], frame_bytes[i+1]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    function automatic logic [31:0] frame_crc32();
        logic [31:0] crc;
        logic        feedback;
        crc = 32'hFFFFFFFF;
        foreach (frame_bytes[n]) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ frame_bytes[n][b];
                crc      = crc >> 1;
                if (feedback) crc = crc ^ 32'hEDB88320;   // Reflected 0x04C11DB7
            end
        end
        return ~crc;
    endfunction

    task automatic build_expected_frame();
        logic [15:0] checksum;
        logic [31:0] fcs;
        frame_bytes.delete();
        append_field(mac_destination, 6);
        append_field(mac_source, 6);
        append_field(48'h0800, 2);
        append_field(48'h4500, 2);
        append_field(48'(payload_bytes.size() + 28), 2);
        append_field(48'(next_identification), 2);
        append_field(48'h4000, 2);                  // Don't fragment
        append_field(48'h4011, 2);                  // TTL 64, UDP
        append_field(48'h0000, 2);
        append_field(48'(ipv4_source), 4);
        append_field(48'(ipv4_destination), 4);
        append_field(48'(udp_source), 2);
        append_field(48'(udp_destination), 2);
        append_field(48'(payload_bytes.size() + 8), 2);
        append_field(48'h0000, 2);                  // UDP checksum unused
        checksum        = header_checksum_of(14);
        frame_bytes[24] = checksum[15:8];
        frame_bytes[25] = checksum[7:0];
        foreach (payload_bytes[i]) frame_bytes.push_back(payload_bytes[i]);
        fcs = frame_crc32();
        for (int i = 0; i < 4; i++) begin
            frame_bytes.push_back(fcs[8*i +: 8]);
        end
        foreach (frame_bytes[i]) begin
            expected_bytes.push_back({i == frame_bytes.size() - 1, frame_bytes[i]});
        end
        next_identification = next_identification + 16'd1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Fabric side

    task automatic send_packet(input int length);
        logic [47:0] next_mac_destination;
        logic [31:0] next_ipv4_destination;
        logic [15:0] next_udp_source;
        logic [15:0] next_udp_destination;
        payload_bytes.delete();
        for (int i = 0; i < length; i++) begin
            payload_bytes.push_back(8'($random(seed)));
        end
        next_mac_destination  = {16'($random(seed)), 32'($random(seed))};
        next_ipv4_destination = 32'($random(seed));
        next_udp_source       = 16'($random(seed));
        next_udp_destination  = 16'($random(seed));
        @(negedge clock);
        while (!transmit_ready) @(negedge clock);
        @(posedge clock);
        mac_destination  <= next_mac_destination;
        ipv4_destination <= next_ipv4_destination;
        udp_source       <= next_udp_source;
        udp_destination  <= next_udp_destination;
        @(negedge clock);
        build_expected_frame();
        foreach (payload_bytes[i]) begin
            @(posedge clock);
            module_transmit_data        <= {i == length - 1, payload_bytes[i]};
            module_transmit_data_enable <= 1'b1;
        end
        @(posedge clock);
        module_transmit_data_enable <= 1'b0;
        @(negedge clock);
        assert (!transmit_ready) else stop_on_error("transmit_ready high after the last byte");
    endtask

    // Switch back-pressure on frames 1 to 3
    always @(posedge clock) begin
        if (frames_received >= 1 && frames_received <= 3) begin
            transmit_data_enable <= 1'($random(seed));
        end else begin
            transmit_data_enable <= 1'b1;
        end
    end

    always @(negedge clock) begin
        if (rst_n && transmit_data_valid && transmit_data_enable) begin
            assert (expected_bytes.size() > 0) else
                stop_on_error("Byte transferred while no frame was expected");
            assert (transmit_data === expected_bytes[0]) else
                stop_on_error($sformatf("Mismatch transmit_data: expected 0x%03h, actual 0x%03h",
                                        expected_bytes[0], transmit_data));
            void'(expected_bytes.pop_front());
            if (transmit_data[8]) begin
                assert (!transmit_ready) else
                    stop_on_error("transmit_ready high before the frame ended");
                frames_received = frames_received + 1;
            end
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clock);
        stop_on_error("Timeout: not all frames arrived in time");
    end

    initial begin
        int total_bytes;
        seed                        = 32'h61f2f419;
        rst_n                       = 1'b0;
        mac_source                  = 48'h02_1a_2b_3c_4d_5e;
        mac_destination             = 48'h02_00_00_00_00_01;
        ipv4_source                 = 32'hc0a8_0a01;
        ipv4_destination            = 32'hc0a8_0a02;
        udp_source                  = 16'd5000;
        udp_destination             = 16'd6000;
        module_transmit_data        = '0;
        module_transmit_data_enable = 1'b0;
        transmit_data_enable        = 1'b1;
        frames_received             = 0;
        next_identification         = 16'd0;
        timeout_cycles              = 0;
        total_bytes                 = 0;

        lengths[0] = 32;
        lengths[4] = 1;
        lengths[7] = MAX_PAYLOAD;
        foreach (lengths[i]) begin
            if (i != 0 && i != 4 && i != 7) lengths[i] = 1 + ($unsigned($random(seed)) % 200);
            total_bytes = total_bytes + lengths[i] + 46 + 50;
        end
        timeout_cycles = 4 * total_bytes + 1000;

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        assert (!transmit_data_valid) else stop_on_error("transmit_data_valid high after reset");
        assert (transmit_ready) else stop_on_error("transmit_ready low after reset");

        foreach (lengths[i]) send_packet(lengths[i]);

        wait (frames_received == PACKET_COUNT);
        @(negedge clock);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/virtual_port_udp_properties.sv
`default_nettype none

module virtual_port_udp_properties (
    input wire       clock,
    input wire       rst_n,
    input wire [8:0] transmit_data,
    input wire       transmit_data_valid,
    input wire       transmit_data_enable,
    input wire       module_transmit_data_enable,
    input wire       transmit_ready
);

    valid_low_after_reset: assert property (
        @(posedge clock) !rst_n |=> !transmit_data_valid
    ) else $error("transmit_data_valid high in the cycle after reset");

    // Switch stalls the output register
    output_held_when_stalled: assert property (
        @(posedge clock) disable iff (!rst_n)
        transmit_data_valid && !transmit_data_enable
            |=> transmit_data_valid && $stable(transmit_data)
    ) else $error("transmit_data changed while stalled by transmit_data_enable");

    no_write_while_busy: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(module_transmit_data_enable && !transmit_ready)
    ) else $error("module_transmit_data_enable high while transmit_ready low");

    last_mark_with_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        transmit_data[8] |-> transmit_data_valid            // Mark only on a valid byte
    ) else $error("transmit_data bit 8 set without transmit_data_valid");

endmodule

bind virtual_port_udp virtual_port_udp_properties properties (
    .clock                       (clock),
    .rst_n                       (rst_n),
    .transmit_data               (transmit_data),
    .transmit_data_valid         (transmit_data_valid),
    .transmit_data_enable        (transmit_data_enable),
    .module_transmit_data_enable (module_transmit_data_enable),
    .transmit_ready              (transmit_ready)
);

`default_nettype wire

//--- hdl/virtual_port_udp.sv
`default_nettype none

module virtual_port_udp #(
    parameter int PAYLOAD_DEPTH = 1472
)(
    input  wire                                clock,
    input  wire                                rst_n,
    input  wire net_header_pkg::mac_addr_t     mac_source,
    input  wire net_header_pkg::mac_addr_t     mac_destination,
    input  wire net_header_pkg::ipv4_addr_t    ipv4_source,
    input  wire net_header_pkg::ipv4_addr_t    ipv4_destination,
    input  wire net_header_pkg::word16_t       udp_source,
    input  wire net_header_pkg::word16_t       udp_destination,
    input  wire port_state_pkg::fabric_byte_t  module_transmit_data,   // From fabric module
    input  wire                                module_transmit_data_enable,
    input  wire                                transmit_data_enable,   // From switch

    output wire                                transmit_ready,
    output port_state_pkg::fabric_byte_t       transmit_data,          // To switch
    output wire                                transmit_data_valid
);

    localparam int ADDRESS_WIDTH = $clog2(PAYLOAD_DEPTH);

    wire [ADDRESS_WIDTH-1:0]        read_address;
    wire [7:0]                      read_data;
    wire                            packet_ready;
    wire                            packet_done;
    net_header_pkg::word16_t        payload_length;
    wire                            checksum_start;
    wire                            checksum_valid;
    net_header_pkg::word16_t        header_checksum;
    net_header_pkg::word16_t        total_length;
    net_header_pkg::word16_t        identification;

    udp_payload_buffer #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) payload_buffer (
        .clock                       (clock),
        .rst_n                       (rst_n),
        .module_transmit_data        (module_transmit_data),
        .module_transmit_data_enable (module_transmit_data_enable),
        .read_address                (read_address),
        .packet_done                 (packet_done),
        .transmit_ready              (transmit_ready),
        .packet_ready                (packet_ready),
        .payload_length              (payload_length),
        .read_data                   (read_data)
    );

    ipv4_checksum_calculator checksum_calculator (
        .clock            (clock),
        .rst_n            (rst_n),
        .checksum_start   (checksum_start),
        .ipv4_source      (ipv4_source),
        .ipv4_destination (ipv4_destination),
        .total_length     (total_length),
        .identification   (identification),
        .header_checksum  (header_checksum),
        .checksum_valid   (checksum_valid)
    );

    ethernet_frame_generator #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) frame_generator (
        .clock                (clock),
        .rst_n                (rst_n),
        .packet_ready         (packet_ready),
        .payload_length       (payload_length),
        .read_data            (read_data),
        .header_checksum      (header_checksum),
        .checksum_valid       (checksum_valid),
        .mac_source           (mac_source),
        .mac_destination      (mac_destination),
        .ipv4_source          (ipv4_source),
        .ipv4_destination     (ipv4_destination),
        .udp_source           (udp_source),
        .udp_destination      (udp_destination),
        .transmit_data_enable (transmit_data_enable),
        .read_address         (read_address),
        .packet_done          (packet_done),
        .checksum_start       (checksum_start),
        .total_length         (total_length),
        .identification       (identification),
        .transmit_data        (transmit_data),
        .transmit_data_valid  (transmit_data_valid)
    );

endmodule

`default_nettype wire

//--- hdl/ethernet_frame_generator.sv
`default_nettype none

module ethernet_frame_generator #(
    parameter int PAYLOAD_DEPTH = 1472,
    localparam int ADDRESS_WIDTH = $clog2(PAYLOAD_DEPTH)
)(
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire                              packet_ready,
    input  wire net_header_pkg::word16_t     payload_length,
    input  wire [7:0]                        read_data,
    input  wire net_header_pkg::word16_t     header_checksum,
    input  wire                              checksum_valid,
    input  wire net_header_pkg::mac_addr_t   mac_source,
    input  wire net_header_pkg::mac_addr_t   mac_destination,
    input  wire net_header_pkg::ipv4_addr_t  ipv4_source,
    input  wire net_header_pkg::ipv4_addr_t  ipv4_destination,
    input  wire net_header_pkg::word16_t     udp_source,
    input  wire net_header_pkg::word16_t     udp_destination,
    input  wire                              transmit_data_enable,

    output logic [ADDRESS_WIDTH-1:0]         read_address,
    output logic                             packet_done,
    output logic                             checksum_start,
    output net_header_pkg::word16_t          total_length,
    output net_header_pkg::word16_t          identification,
    output port_state_pkg::fabric_byte_t     transmit_data,
    output logic                             transmit_data_valid
);

    localparam net_header_pkg::word16_t HEADER_BYTES = net_header_pkg::ETH_HEADER_BYTES
        + net_header_pkg::IPV4_HEADER_BYTES + net_header_pkg::UDP_HEADER_BYTES;
    localparam net_header_pkg::word16_t CHECKSUM_BYTE = net_header_pkg::ETH_HEADER_BYTES + 16'd10;

    port_state_pkg::generator_state_t generator_state;
    net_header_pkg::word16_t          byte_count;
    net_header_pkg::mac_addr_t        sampled_mac_destination;
    net_header_pkg::ipv4_addr_t       sampled_ipv4_destination;
    net_header_pkg::word16_t          sampled_udp_source;
    net_header_pkg::word16_t          sampled_udp_destination;
    net_header_pkg::word16_t          udp_length;
    logic [8*HEADER_BYTES-1:0]        header_bytes;
    port_state_pkg::fabric_byte_t     next_byte;
    logic                             have_byte;
    logic                             load_byte;
    logic                             fcs_clear;
    logic                             fcs_data_enable;
    logic [31:0]                      fcs;
    logic [7:0]                       fcs_byte;

    assign checksum_start = (generator_state == port_state_pkg::GENERATOR_IDLE) && packet_ready;
    assign fcs_clear      = checksum_start;

    assign total_length = payload_length + net_header_pkg::IPV4_HEADER_BYTES
                        + net_header_pkg::UDP_HEADER_BYTES;
    assign udp_length   = payload_length + net_header_pkg::UDP_HEADER_BYTES;

    // First byte on the wire sits in the top byte
    assign header_bytes = {sampled_mac_destination, mac_source, net_header_pkg::ETHERTYPE_IPV4,
                           net_header_pkg::IPV4_VERSION_IHL, 8'h00, total_length, identification,
                           net_header_pkg::IPV4_FLAGS_FRAGMENT, net_header_pkg::IPV4_TTL,
                           net_header_pkg::IPV4_PROTOCOL_UDP, header_checksum, ipv4_source,
                           sampled_ipv4_destination, sampled_udp_source, sampled_udp_destination,
                           udp_length, 16'h0000};

    assign fcs_byte = ~fcs[8 * byte_count[1:0] +: 8];   // Complement, low byte first

    //////////////////////////////////////////////////////////////////////
    // Byte selection

    always_comb begin
        next_byte = '0;
        have_byte = 1'b0;
        case (generator_state)
            port_state_pkg::GENERATOR_HEADER: begin
                next_byte[7:0] = header_bytes[8 * (HEADER_BYTES - 1'b1 - byte_count) +: 8];
                have_byte      = !(byte_count == CHECKSUM_BYTE && !checksum_valid);
            end
            port_state_pkg::GENERATOR_PAYLOAD: begin
                next_byte[7:0] = read_data;
                have_byte      = 1'b1;
            end
            port_state_pkg::GENERATOR_FCS: begin
                next_byte = {byte_count == net_header_pkg::FCS_BYTES - 1'b1, fcs_byte};
                have_byte = byte_count < net_header_pkg::FCS_BYTES;
            end
            default: ;
        endcase
    end

    assign load_byte       = have_byte && (!transmit_data_valid || transmit_data_enable);
    assign fcs_data_enable = load_byte && generator_state != port_state_pkg::GENERATOR_FCS;
    assign packet_done     = transmit_data_valid && transmit_data_enable && transmit_data[8];

    // Prefetch the next payload byte as the current one leaves
    always_comb begin
        read_address = '0;
        if (generator_state == port_state_pkg::GENERATOR_PAYLOAD) begin
            read_address = load_byte ? byte_count[ADDRESS_WIDTH-1:0] + 1'b1
                                     : byte_count[ADDRESS_WIDTH-1:0];
        end
    end

    frame_check_sequence_generator fcs_generator (
        .clock           (clock),
        .rst_n           (rst_n),
        .fcs_clear       (fcs_clear),
        .fcs_data        (next_byte[7:0]),
        .fcs_data_enable (fcs_data_enable),
        .fcs             (fcs)
    );

    //////////////////////////////////////////////////////////////////////
    // Sequencing and output register

    always_ff @(posedge clock) begin
        if (checksum_start) begin
            sampled_mac_destination  <= mac_destination;
            sampled_ipv4_destination <= ipv4_destination;
            sampled_udp_source       <= udp_source;
            sampled_udp_destination  <= udp_destination;
        end
        if (load_byte) begin
            transmit_data <= next_byte;
        end else if (!transmit_data_valid || transmit_data_enable) begin
            transmit_data[8] <= 1'b0;                   // No mark once the byte has left
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            generator_state     <= port_state_pkg::GENERATOR_IDLE;
            byte_count          <= '0;
            identification      <= '0;
            transmit_data_valid <= 1'b0;
        end else begin
            if (!transmit_data_valid || transmit_data_enable) begin
                transmit_data_valid <= have_byte;
            end
            case (generator_state)
                port_state_pkg::GENERATOR_IDLE: begin
                    if (packet_ready) begin
                        generator_state <= port_state_pkg::GENERATOR_HEADER;
                        byte_count      <= '0;
                    end
                end
                port_state_pkg::GENERATOR_HEADER: begin
                    if (load_byte && byte_count == HEADER_BYTES - 1'b1) begin
                        generator_state <= port_state_pkg::GENERATOR_PAYLOAD;
                        byte_count      <= '0;
                    end else if (load_byte) begin
                        byte_count <= byte_count + 1'b1;
                    end
                end
                port_state_pkg::GENERATOR_PAYLOAD: begin
                    if (load_byte && byte_count == payload_length - 1'b1) begin
                        generator_state <= port_state_pkg::GENERATOR_FCS;
                        byte_count      <= '0;
                    end else if (load_byte) begin
                        byte_count <= byte_count + 1'b1;
                    end
                end
                port_state_pkg::GENERATOR_FCS: begin
                    if (load_byte) begin
                        byte_count <= byte_count + 1'b1;
                    end
                    if (packet_done) begin              // Last FCS byte taken
                        generator_state <= port_state_pkg::GENERATOR_IDLE;
                        identification  <= identification + 1'b1;
                    end
                end
                default: generator_state <= port_state_pkg::GENERATOR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/frame_check_sequence_generator.sv
`default_nettype none

module frame_check_sequence_generator (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         fcs_clear,
    input  wire [7:0]   fcs_data,
    input  wire         fcs_data_enable,

    output logic [31:0] fcs
);

    localparam logic [31:0] POLYNOMIAL = 32'hEDB88320;  // 0x04C11DB7 bit reversed

    logic [31:0] crc_next;

    // LSB first, one bit per step
    always_comb begin
        crc_next = fcs ^ {24'h000000, fcs_data};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ POLYNOMIAL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fcs <= '1;
        end else if (fcs_clear) begin
            fcs <= '1;
        end else if (fcs_data_enable) begin
            fcs <= crc_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ipv4_checksum_calculator.sv
`default_nettype none

module ipv4_checksum_calculator (
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire                              checksum_start,
    input  wire net_header_pkg::ipv4_addr_t  ipv4_source,
    input  wire net_header_pkg::ipv4_addr_t  ipv4_destination,
    input  wire net_header_pkg::word16_t     total_length,
    input  wire net_header_pkg::word16_t     identification,

    output net_header_pkg::word16_t          header_checksum,
    output logic                             checksum_valid
);

    port_state_pkg::checksum_state_t checksum_state;
    logic [3:0]                      word_index;
    logic [31:0]                     accumulator;
    net_header_pkg::ipv4_addr_t      source_address;
    net_header_pkg::ipv4_addr_t      destination_address;
    net_header_pkg::word16_t         header_word;
    logic [16:0]                     fold_once;
    net_header_pkg::word16_t         fold_twice;

    always_comb begin
        case (word_index)
            4'd0:    header_word = {net_header_pkg::IPV4_VERSION_IHL, 8'h00};
            4'd1:    header_word = total_length;
            4'd2:    header_word = identification;
            4'd3:    header_word = net_header_pkg::IPV4_FLAGS_FRAGMENT;
            4'd4:    header_word = {net_header_pkg::IPV4_TTL, net_header_pkg::IPV4_PROTOCOL_UDP};
            4'd6:    header_word = source_address[31:16];
            4'd7:    header_word = source_address[15:0];
            4'd8:    header_word = destination_address[31:16];
            4'd9:    header_word = destination_address[15:0];
            default: header_word = '0;                  // Checksum field
        endcase
    end

    // Ten words fit in 20 bits so two folds clear every carry
    assign fold_once  = {1'b0, accumulator[15:0]} + {1'b0, accumulator[31:16]};
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    always_ff @(posedge clock) begin
        if (checksum_start) begin
            source_address      <= ipv4_source;
            destination_address <= ipv4_destination;
            accumulator         <= '0;
            word_index          <= '0;
        end else if (checksum_state == port_state_pkg::CHECKSUM_SUMMING) begin
            accumulator <= accumulator + 32'(header_word);
            word_index  <= word_index + 1'b1;
        end
        if (checksum_state == port_state_pkg::CHECKSUM_FOLDING) begin
            header_checksum <= ~fold_twice;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            checksum_state <= port_state_pkg::CHECKSUM_IDLE;
            checksum_valid <= 1'b0;
        end else if (checksum_start) begin
            checksum_state <= port_state_pkg::CHECKSUM_SUMMING;
            checksum_valid <= 1'b0;
        end else if (checksum_state == port_state_pkg::CHECKSUM_SUMMING) begin
            if (word_index == 4'(net_header_pkg::IPV4_HEADER_WORDS - 1)) begin
                checksum_state <= port_state_pkg::CHECKSUM_FOLDING;
            end
        end else if (checksum_state == port_state_pkg::CHECKSUM_FOLDING) begin
            checksum_state <= port_state_pkg::CHECKSUM_IDLE;
            checksum_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/udp_payload_buffer.sv
`default_nettype none

module udp_payload_buffer #(
    parameter int PAYLOAD_DEPTH = 1472,
    localparam int ADDRESS_WIDTH = $clog2(PAYLOAD_DEPTH)
)(
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire port_state_pkg::fabric_byte_t module_transmit_data,
    input  wire                           module_transmit_data_enable,
    input  wire [ADDRESS_WIDTH-1:0]       read_address,
    input  wire                           packet_done,

    output logic                          transmit_ready,
    output logic                          packet_ready,
    output net_header_pkg::word16_t       payload_length,
    output logic [7:0]                    read_data
);

    logic [7:0]                    payload_ram [PAYLOAD_DEPTH];
    logic [ADDRESS_WIDTH-1:0]      write_address;
    port_state_pkg::buffer_state_t buffer_state;
    logic                          write_enable;
    logic                          last_byte;

    assign transmit_ready = (buffer_state == port_state_pkg::BUFFER_FILLING);
    assign packet_ready   = (buffer_state == port_state_pkg::BUFFER_HOLDING);

    assign write_enable = module_transmit_data_enable && transmit_ready;
    assign last_byte    = write_enable && module_transmit_data[8];

    // Payload RAM with registered read port
    always_ff @(posedge clock) begin
        if (write_enable) begin
            payload_ram[write_address] <= module_transmit_data[7:0];
        end
        read_data <= payload_ram[read_address];
    end

    always_ff @(posedge clock) begin
        if (last_byte) begin
            payload_length <= net_header_pkg::word16_t'(write_address) + 16'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            buffer_state  <= port_state_pkg::BUFFER_FILLING;
            write_address <= '0;
        end else begin
            case (buffer_state)
                port_state_pkg::BUFFER_FILLING: begin
                    if (write_enable) begin
                        write_address <= write_address + 1'b1;
                    end
                    if (last_byte) begin
                        buffer_state <= port_state_pkg::BUFFER_HOLDING;
                    end
                end
                port_state_pkg::BUFFER_HOLDING: begin
                    // Held until the frame has left
                    if (packet_done) begin
                        buffer_state  <= port_state_pkg::BUFFER_FILLING;
                        write_address <= '0;
                    end
                end
                default: buffer_state <= port_state_pkg::BUFFER_FILLING;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/port_state_pkg.sv
`default_nettype none

package port_state_pkg;

    // Data in 7..0 with last-byte mark in bit 8
    typedef logic [8:0] fabric_byte_t;

    typedef enum logic {
        BUFFER_FILLING,
        BUFFER_HOLDING
    } buffer_state_t;

    typedef enum logic [1:0] {
        GENERATOR_IDLE,
        GENERATOR_HEADER,
        GENERATOR_PAYLOAD,
        GENERATOR_FCS
    } generator_state_t;

    typedef enum logic [1:0] {
        CHECKSUM_IDLE,
        CHECKSUM_SUMMING,
        CHECKSUM_FOLDING
    } checksum_state_t;

endpackage

`default_nettype wire

//--- hdl/net_header_pkg.sv
`default_nettype none

package net_header_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] word16_t;

    //////////////////////////////////////////////////////////////////////
    // Fixed header fields

    localparam word16_t ETHERTYPE_IPV4 = 16'h0800;

    localparam logic [7:0] IPV4_VERSION_IHL  = 8'h45;   // Version 4, five words
    localparam logic [7:0] IPV4_TTL          = 8'd64;
    localparam logic [7:0] IPV4_PROTOCOL_UDP = 8'd17;

    localparam word16_t IPV4_FLAGS_FRAGMENT = 16'h4000; // DF set, offset 0

    //////////////////////////////////////////////////////////////////////
    // Sizes in bytes

    localparam word16_t ETH_HEADER_BYTES  = 16'd14;
    localparam word16_t IPV4_HEADER_BYTES = 16'd20;
    localparam word16_t UDP_HEADER_BYTES  = 16'd8;
    localparam word16_t FCS_BYTES         = 16'd4;

    localparam int IPV4_HEADER_WORDS = 10;

endpackage

`default_nettype wire
